//--- src/xbar_params.svh
// crossbar build constants
// bus widths, port counts, read tracking depth, the error word
// returned for disabled slaves and the configuration register map
`ifndef XBAR_PARAMS_SVH
`define XBAR_PARAMS_SVH

// bus widths
`define XBAR_ADDR_W 32
`define XBAR_DATA_W 32

// port counts
`define XBAR_NUM_M 2
`define XBAR_NUM_S 2

// outstanding reads per slave and per master
`define XBAR_TRANS_BUF 4

// read data for a disabled slave
`define XBAR_ERR_DATA 32'hDEAD_BEEF

// axi4-lite register offsets
`define XBAR_REG_CTRL 8'h00
`define XBAR_REG_ERR0 8'h04
`define XBAR_REG_ERR1 8'h08

`endif

//--- src/xbar_pkg.sv
// crossbar shared types
// address, data and index words plus the packed request, response
// and configuration structs passed between the ports
`default_nettype none
`include "xbar_params.svh"

package xbar_pkg;

	typedef logic [`XBAR_ADDR_W-1:0] xbar_addr_t;
	typedef logic [`XBAR_DATA_W-1:0] xbar_data_t;

	// master and slave index
	typedef logic [$clog2(`XBAR_NUM_M)-1:0] xbar_mid_t;
	typedef logic [$clog2(`XBAR_NUM_S)-1:0] xbar_sid_t;

	// decode error counter
	typedef logic [15:0] xbar_cnt_t;

	// request side of the bus, held stable until req and ack meet
	typedef struct packed {
		logic       req;
		logic       we;
		xbar_addr_t addr;
		xbar_data_t wdata;
	} xbar_req_t;

	// single-cycle read response
	typedef struct packed {
		logic       resp;
		xbar_data_t rdata;
	} xbar_resp_t;

	typedef struct packed {
		logic [`XBAR_NUM_S-1:0] s_en;
		logic                   rr_mode;
	} xbar_cfg_t;

endpackage

`default_nettype wire

//--- src/xbar_master_port.sv
// crossbar master port
// decodes the target slave from the top address bit, answers requests
// to disabled slaves locally and keeps this master's reads in order
`timescale 1ns/10ps
`default_nettype none
`include "xbar_params.svh"

module xbar_master_port
(
	input  logic                   rst_n_i,
	input  logic                   memread_grant,
	input  xbar_pkg::xbar_req_t    m_req_i,
	output logic                   m_ack_o,
	output xbar_pkg::xbar_resp_t   m_resp_o,
	output xbar_pkg::xbar_req_t    s_req_o [`XBAR_NUM_S],
	input  logic [`XBAR_NUM_S-1:0] s_ack_i,
	input  xbar_pkg::xbar_resp_t   s_resp_i [`XBAR_NUM_S],
	input  xbar_pkg::xbar_cfg_t    cfg_i,
	output logic                   err_o
);
	import xbar_pkg::*;

	localparam int CNT_W = $clog2(`XBAR_TRANS_BUF + 1);

	xbar_sid_t              sel;
	logic                   sel_en;
	logic                   is_rd;
	logic                   rd_blk;
	logic                   fwd;
	logic                   local_acc;
	logic                   rd_inc;
	logic                   err_pend;
	logic [CNT_W-1:0]       rd_cnt;
	xbar_sid_t              rd_sid;
	logic [`XBAR_NUM_S-1:0] s_req_vec;

	assign sel    = xbar_sid_t'(m_req_i.addr[`XBAR_ADDR_W-1]);
	assign sel_en = cfg_i.s_en[sel];
	assign is_rd  = m_req_i.req && !m_req_i.we;

	// a read waits while older reads go elsewhere, to a disabled slave,
	// or when the tracking count is exhausted
	assign rd_blk = is_rd && (rd_cnt != '0) &&
		((rd_sid != sel) || !sel_en || (rd_cnt == CNT_W'(`XBAR_TRANS_BUF)));

	assign fwd       = m_req_i.req && sel_en && !rd_blk;
	assign local_acc = m_req_i.req && !sel_en && !rd_blk;
	assign m_ack_o   = fwd ? s_ack_i[sel] : local_acc;
	assign rd_inc    = is_rd && m_ack_o;
	assign err_o     = local_acc;

	always_comb
	begin
		for (int s = 0; s < `XBAR_NUM_S; s++)
		begin
			s_req_o[s]     = m_req_i;
			s_req_o[s].req = fwd && (sel == xbar_sid_t'(s));
			s_req_vec[s]   = s_req_o[s].req;
		end
	end

	// all pending reads target rd_sid, so only that slave can answer
	always_comb
	begin
		m_resp_o.resp  = err_pend || s_resp_i[rd_sid].resp;
		m_resp_o.rdata = err_pend ? `XBAR_ERR_DATA : s_resp_i[rd_sid].rdata;
	end

	always_ff @(posedge memread_grant or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			rd_cnt   <= '0;
			rd_sid   <= '0;
			err_pend <= 1'b0;
		end
		else
		begin
			err_pend <= local_acc && !m_req_i.we;
			if (rd_inc)
				rd_sid <= sel;
			if (rd_inc && !m_resp_o.resp)
				rd_cnt <= rd_cnt + 1'b1;
			else if (!rd_inc && m_resp_o.resp)
				rd_cnt <= rd_cnt - 1'b1;
		end
	end

	a_one_slave_req: assert property (@(posedge memread_grant) disable iff (!rst_n_i)
		$onehot0(s_req_vec))
		else $error("master port drives more than one slave request");

	// a response, local or from a slave, must match a tracked read
	a_resp_tracked: assert property (@(posedge memread_grant) disable iff (!rst_n_i)
		m_resp_o.resp |-> (rd_cnt != '0))
		else $error("response without an outstanding read");

endmodule

`default_nettype wire

//--- src/xbar_slave_port.sv
// crossbar slave port
// arbitrates the masters onto one slave, round-robin or fixed priority,
// and queues read owners so slave responses go back to the right master
`timescale 1ns/10ps
`default_nettype none
`include "xbar_params.svh"

module xbar_slave_port
(
	input  logic                   rst_n_i,
	input  logic                   memread_grant,
	input  xbar_pkg::xbar_req_t    m_req_i [`XBAR_NUM_M],
	output logic [`XBAR_NUM_M-1:0] m_ack_o,
	output xbar_pkg::xbar_resp_t   m_resp_o [`XBAR_NUM_M],
	output xbar_pkg::xbar_req_t    s_req_o,
	input  logic                   s_ack_i,
	input  xbar_pkg::xbar_resp_t   s_resp_i,
	input  logic                   rr_mode_i
);
	import xbar_pkg::*;

	localparam int PTR_W = $clog2(`XBAR_TRANS_BUF);

	logic [`XBAR_NUM_M-1:0] elig;
	xbar_mid_t              win;
	logic                   any;
	xbar_mid_t              last_win;
	logic                   locked;
	xbar_mid_t              lock_id;
	logic                   accept;
	logic                   push;
	logic                   pop;
	logic                   fifo_full;
	xbar_mid_t              owner_mem [`XBAR_TRANS_BUF];
	logic [PTR_W-1:0]       wr_ptr;
	logic [PTR_W-1:0]       rd_ptr;
	logic [PTR_W:0]         fifo_cnt;

	assign fifo_full = (fifo_cnt == (PTR_W+1)'(`XBAR_TRANS_BUF));

	// reads need a free owner slot
	always_comb
	begin
		for (int m = 0; m < `XBAR_NUM_M; m++)
			elig[m] = m_req_i[m].req && (m_req_i[m].we || !fifo_full);
	end

	always_comb
	begin
		xbar_mid_t idx;
		win = '0;
		any = 1'b0;
		for (int i = 0; i < `XBAR_NUM_M; i++)
		begin
			// search starts just after the last winner in round-robin mode
			if (rr_mode_i)
				idx = xbar_mid_t'(last_win + 1 + i);
			else
				idx = xbar_mid_t'(i);
			if (!any && elig[idx])
			begin
				win = idx;
				any = 1'b1;
			end
		end
		// keep a stalled grant until the slave takes it
		if (locked && elig[lock_id])
		begin
			win = lock_id;
			any = 1'b1;
		end
	end

	always_comb
	begin
		s_req_o     = m_req_i[win];
		s_req_o.req = any;
		for (int m = 0; m < `XBAR_NUM_M; m++)
		begin
			m_ack_o[m]        = any && s_ack_i && (win == xbar_mid_t'(m));
			m_resp_o[m].resp  = s_resp_i.resp && (owner_mem[rd_ptr] == xbar_mid_t'(m));
			m_resp_o[m].rdata = s_resp_i.rdata;
		end
	end

	assign accept = any && s_ack_i;
	assign push   = accept && !m_req_i[win].we;
	assign pop    = s_resp_i.resp;

	always_ff @(posedge memread_grant or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			last_win <= '0;
			locked   <= 1'b0;
			lock_id  <= '0;
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			fifo_cnt <= '0;
		end
		else
		begin
			locked  <= any && !s_ack_i;
			lock_id <= win;
			if (accept)
				last_win <= win;
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				fifo_cnt <= fifo_cnt + 1'b1;
			else if (!push && pop)
				fifo_cnt <= fifo_cnt - 1'b1;
		end
	end

	// owner ids
	always_ff @(posedge memread_grant)
	begin
		if (push)
			owner_mem[wr_ptr] <= win;
	end

	a_resp_has_owner: assert property (@(posedge memread_grant) disable iff (!rst_n_i)
		s_resp_i.resp |-> (fifo_cnt != '0))
		else $error("slave response with no read outstanding");

	a_no_push_full: assert property (@(posedge memread_grant) disable iff (!rst_n_i)
		push |-> !fifo_full)
		else $error("read granted with owner fifo full");

endmodule

`default_nettype wire

//--- src/xbar_cfg_regs.sv
// crossbar configuration registers on axi4-lite
// CTRL holds the slave enables and arbitration mode, ERR0 and ERR1
// count requests each master sent to a disabled slave
`timescale 1ns/10ps
`default_nettype none
`include "xbar_params.svh"

module xbar_cfg_regs
(
	input  logic                   rst_n_i,
	input  logic                   memread_grant,
	input  xbar_pkg::xbar_addr_t   s_axi_awaddr_i,
	input  logic                   s_axi_awvalid_i,
	output logic                   s_axi_awready_o,
	input  xbar_pkg::xbar_data_t   s_axi_wdata_i,
	input  logic                   s_axi_wvalid_i,
	output logic                   s_axi_wready_o,
	output logic [1:0]             s_axi_bresp_o,
	output logic                   s_axi_bvalid_o,
	input  logic                   s_axi_bready_i,
	input  xbar_pkg::xbar_addr_t   s_axi_araddr_i,
	input  logic                   s_axi_arvalid_i,
	output logic                   s_axi_arready_o,
	output xbar_pkg::xbar_data_t   s_axi_rdata_o,
	output logic [1:0]             s_axi_rresp_o,
	output logic                   s_axi_rvalid_o,
	input  logic                   s_axi_rready_i,
	input  logic [`XBAR_NUM_M-1:0] err_i,
	output xbar_pkg::xbar_cfg_t    cfg_o
);
	import xbar_pkg::*;

	typedef enum logic [1:0] {
		W_IDLE,
		W_GOT_ADDR,
		W_GOT_DATA,
		W_RESP
	} wr_state_t;

	wr_state_t              wr_state;
	xbar_addr_t             aw_addr_q;
	xbar_data_t             w_data_q;
	logic                   aw_hs;
	logic                   w_hs;
	logic                   b_hs;
	logic                   ar_hs;
	logic                   wr_ctrl;
	logic [`XBAR_NUM_M-1:0] err_clr;
	xbar_cfg_t              cfg_q;
	xbar_cnt_t              err_cnt [`XBAR_NUM_M];
	logic                   rvalid_q;
	xbar_data_t             rdata_q;
	xbar_data_t             rd_mux;

	assign s_axi_awready_o = (wr_state == W_IDLE) || (wr_state == W_GOT_DATA);
	assign s_axi_wready_o  = (wr_state == W_IDLE) || (wr_state == W_GOT_ADDR);
	assign s_axi_bvalid_o  = (wr_state == W_RESP);
	assign s_axi_bresp_o   = 2'b00;

	assign aw_hs = s_axi_awvalid_i && s_axi_awready_o;
	assign w_hs  = s_axi_wvalid_i && s_axi_wready_o;
	assign b_hs  = s_axi_bvalid_o && s_axi_bready_i;

	// register write lands on the b handshake
	assign wr_ctrl    = b_hs && (aw_addr_q[7:0] == `XBAR_REG_CTRL);
	assign err_clr[0] = b_hs && (aw_addr_q[7:0] == `XBAR_REG_ERR0);
	assign err_clr[1] = b_hs && (aw_addr_q[7:0] == `XBAR_REG_ERR1);

	// aw and w in either order
	always_ff @(posedge memread_grant or negedge rst_n_i)
	begin
		if (!rst_n_i)
			wr_state <= W_IDLE;
		else
		begin
			case (wr_state)
				W_IDLE:
				begin
					if (aw_hs && w_hs)
						wr_state <= W_RESP;
					else if (aw_hs)
						wr_state <= W_GOT_ADDR;
					else if (w_hs)
						wr_state <= W_GOT_DATA;
				end
				W_GOT_ADDR:
					if (w_hs)
						wr_state <= W_RESP;
				W_GOT_DATA:
					if (aw_hs)
						wr_state <= W_RESP;
				default:
					if (b_hs)
						wr_state <= W_IDLE;
			endcase
		end
	end

	always_ff @(posedge memread_grant)
	begin
		if (aw_hs)
			aw_addr_q <= s_axi_awaddr_i;
		if (w_hs)
			w_data_q <= s_axi_wdata_i;
		if (ar_hs)
			rdata_q <= rd_mux;
	end

	always_ff @(posedge memread_grant or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			cfg_q.s_en    <= '1;
			cfg_q.rr_mode <= 1'b1;
			for (int m = 0; m < `XBAR_NUM_M; m++)
				err_cnt[m] <= '0;
		end
		else
		begin
			if (wr_ctrl)
			begin
				cfg_q.s_en    <= w_data_q[`XBAR_NUM_S-1:0];
				cfg_q.rr_mode <= w_data_q[`XBAR_NUM_S];
			end
			// clearing wins over a same-cycle error, counters saturate
			for (int m = 0; m < `XBAR_NUM_M; m++)
			begin
				if (err_clr[m])
					err_cnt[m] <= '0;
				else if (err_i[m] && (err_cnt[m] != '1))
					err_cnt[m] <= err_cnt[m] + 1'b1;
			end
		end
	end

	assign cfg_o = cfg_q;

	always_comb
	begin
		rd_mux = '0;
		case (s_axi_araddr_i[7:0])
			`XBAR_REG_CTRL:
			begin
				rd_mux[`XBAR_NUM_S-1:0] = cfg_q.s_en;
				rd_mux[`XBAR_NUM_S]     = cfg_q.rr_mode;
			end
			`XBAR_REG_ERR0: rd_mux = xbar_data_t'(err_cnt[0]);
			`XBAR_REG_ERR1: rd_mux = xbar_data_t'(err_cnt[1]);
			default:        rd_mux = '0;
		endcase
	end

	// one read in flight, data registered on the ar handshake
	assign s_axi_arready_o = !rvalid_q;
	assign ar_hs           = s_axi_arvalid_i && s_axi_arready_o;
	assign s_axi_rvalid_o  = rvalid_q;
	assign s_axi_rdata_o   = rdata_q;
	assign s_axi_rresp_o   = 2'b00;

	always_ff @(posedge memread_grant or negedge rst_n_i)
	begin
		if (!rst_n_i)
			rvalid_q <= 1'b0;
		else if (ar_hs)
			rvalid_q <= 1'b1;
		else if (s_axi_rready_i)
			rvalid_q <= 1'b0;
	end

	a_bvalid_hold: assert property (@(posedge memread_grant) disable iff (!rst_n_i)
		(s_axi_bvalid_o && !s_axi_bready_i) |=> s_axi_bvalid_o)
		else $error("bvalid dropped before bready");

endmodule

`default_nettype wire

//--- src/xbar_top.sv
// two by two memory crossbar
// master ports feed both slave ports, the configuration block
// sets slave enables and arbitration mode for all of them
`timescale 1ns/10ps
`default_nettype none
`include "xbar_params.svh"

module xbar_top
(
	input  logic                   rst_n_i,
	input  logic                   memread_grant,
	input  xbar_pkg::xbar_req_t    m_req_i [`XBAR_NUM_M],
	output logic [`XBAR_NUM_M-1:0] m_ack_o,
	output xbar_pkg::xbar_resp_t   m_resp_o [`XBAR_NUM_M],
	output xbar_pkg::xbar_req_t    s_req_o [`XBAR_NUM_S],
	input  logic [`XBAR_NUM_S-1:0] s_ack_i,
	input  xbar_pkg::xbar_resp_t   s_resp_i [`XBAR_NUM_S],
	input  xbar_pkg::xbar_addr_t   s_axi_awaddr_i,
	input  logic                   s_axi_awvalid_i,
	output logic                   s_axi_awready_o,
	input  xbar_pkg::xbar_data_t   s_axi_wdata_i,
	input  logic                   s_axi_wvalid_i,
	output logic                   s_axi_wready_o,
	output logic [1:0]             s_axi_bresp_o,
	output logic                   s_axi_bvalid_o,
	input  logic                   s_axi_bready_i,
	input  xbar_pkg::xbar_addr_t   s_axi_araddr_i,
	input  logic                   s_axi_arvalid_i,
	output logic                   s_axi_arready_o,
	output xbar_pkg::xbar_data_t   s_axi_rdata_o,
	output logic [1:0]             s_axi_rresp_o,
	output logic                   s_axi_rvalid_o,
	input  logic                   s_axi_rready_i
);
	import xbar_pkg::*;

	// master-major and slave-major views of the same links
	xbar_req_t              m2s_req    [`XBAR_NUM_M][`XBAR_NUM_S];
	xbar_req_t              s_req_in   [`XBAR_NUM_S][`XBAR_NUM_M];
	logic [`XBAR_NUM_M-1:0] s_ack_out  [`XBAR_NUM_S];
	logic [`XBAR_NUM_S-1:0] m_ack_in   [`XBAR_NUM_M];
	xbar_resp_t             s_resp_out [`XBAR_NUM_S][`XBAR_NUM_M];
	xbar_resp_t             m_resp_in  [`XBAR_NUM_M][`XBAR_NUM_S];
	logic [`XBAR_NUM_M-1:0] err;
	xbar_cfg_t              cfg;

	for (genvar m = 0; m < `XBAR_NUM_M; m++)
	begin : g_link_m
		for (genvar s = 0; s < `XBAR_NUM_S; s++)
		begin : g_link_s
			assign s_req_in[s][m]  = m2s_req[m][s];
			assign m_ack_in[m][s]  = s_ack_out[s][m];
			assign m_resp_in[m][s] = s_resp_out[s][m];
		end
	end

	for (genvar m = 0; m < `XBAR_NUM_M; m++)
	begin : g_mport
		xbar_master_port u_mport
		(
			.rst_n_i       (rst_n_i),
			.memread_grant (memread_grant),
			.m_req_i       (m_req_i[m]),
			.m_ack_o       (m_ack_o[m]),
			.m_resp_o      (m_resp_o[m]),
			.s_req_o       (m2s_req[m]),
			.s_ack_i       (m_ack_in[m]),
			.s_resp_i      (m_resp_in[m]),
			.cfg_i         (cfg),
			.err_o         (err[m])
		);
	end

	for (genvar s = 0; s < `XBAR_NUM_S; s++)
	begin : g_sport
		xbar_slave_port u_sport
		(
			.rst_n_i       (rst_n_i),
			.memread_grant (memread_grant),
			.m_req_i       (s_req_in[s]),
			.m_ack_o       (s_ack_out[s]),
			.m_resp_o      (s_resp_out[s]),
			.s_req_o       (s_req_o[s]),
			.s_ack_i       (s_ack_i[s]),
			.s_resp_i      (s_resp_i[s]),
			.rr_mode_i     (cfg.rr_mode)
		);
	end

	xbar_cfg_regs u_cfg
	(
		.rst_n_i         (rst_n_i),
		.memread_grant   (memread_grant),
		.s_axi_awaddr_i  (s_axi_awaddr_i),
		.s_axi_awvalid_i (s_axi_awvalid_i),
		.s_axi_awready_o (s_axi_awready_o),
		.s_axi_wdata_i   (s_axi_wdata_i),
		.s_axi_wvalid_i  (s_axi_wvalid_i),
		.s_axi_wready_o  (s_axi_wready_o),
		.s_axi_bresp_o   (s_axi_bresp_o),
		.s_axi_bvalid_o  (s_axi_bvalid_o),
		.s_axi_bready_i  (s_axi_bready_i),
		.s_axi_araddr_i  (s_axi_araddr_i),
		.s_axi_arvalid_i (s_axi_arvalid_i),
		.s_axi_arready_o (s_axi_arready_o),
		.s_axi_rdata_o   (s_axi_rdata_o),
		.s_axi_rresp_o   (s_axi_rresp_o),
		.s_axi_rvalid_o  (s_axi_rvalid_o),
		.s_axi_rready_i  (s_axi_rready_i),
		.err_i           (err),
		.cfg_o           (cfg)
	);

endmodule

`default_nettype wire

//--- testbench/xbar_checker.sv
// crossbar response checker
// queues expected read data per master and for the register port,
// compares every response in arrival order and counts the errors
`timescale 1ns/10ps
`default_nettype none
`include "xbar_params.svh"

module xbar_checker
(
	input  logic                   rst_n_i,
	input  logic                   memread_grant,
	input  xbar_pkg::xbar_req_t    m_req_i [`XBAR_NUM_M],
	input  logic [`XBAR_NUM_M-1:0] m_ack_i,
	input  xbar_pkg::xbar_resp_t   m_resp_i [`XBAR_NUM_M],
	input  logic                   bvalid_i,
	input  logic                   bready_i,
	input  logic [1:0]             bresp_i,
	input  logic                   rvalid_i,
	input  logic                   rready_i,
	input  xbar_pkg::xbar_data_t   rdata_i,
	input  logic [1:0]             rresp_i,
	output logic                   idle_o,
	output int                     err_cnt_o
);
	import xbar_pkg::*;

	// axi4-lite okay response code
	localparam logic [1:0] RESP_OKAY = 2'b00;

	string      rd_name [`XBAR_NUM_M][$];
	xbar_data_t rd_exp [`XBAR_NUM_M][$];
	string      reg_name [$];
	xbar_data_t reg_exp [$];
	int         n_tests = 0;
	int         n_err = 0;
	int         n_pend = 0;
	logic       b_seen = 1'b0;
	logic [1:0] bresp_q;

	assign idle_o    = (n_pend == 0);
	assign err_cnt_o = n_err;

	task automatic expect_read(input int m, input string name, input xbar_data_t exp);
		rd_name[m].push_back(name);
		rd_exp[m].push_back(exp);
		n_pend++;
	endtask

	task automatic expect_reg(input string name, input xbar_data_t exp);
		reg_name.push_back(name);
		reg_exp.push_back(exp);
		n_pend++;
	endtask

	task automatic note_write(input string name);
		n_tests++;
		$display("ok     %s  write accepted", name);
	endtask

	// register write, the b channel must have answered okay
	task automatic note_reg_write(input string name);
		n_tests++;
		if (!b_seen)
		begin
			n_err++;
			$display("error: %s finished without a write response", name);
		end
		else if (bresp_q !== RESP_OKAY)
		begin
			n_err++;
			$display("** Error %s: expected bresp %b, actual %b", name, RESP_OKAY, bresp_q);
		end
		else
			$display("ok     %s  write accepted", name);
		b_seen = 1'b0;
	endtask

	task automatic judge(input string name, input xbar_data_t exp, input xbar_data_t act);
		n_tests++;
		n_pend--;
		if (act === exp)
			$display("ok     %s  data %h", name, act);
		else
		begin
			n_err++;
			$display("** Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic judge_reg(input string name, input xbar_data_t exp, input xbar_data_t act,
		input logic [1:0] resp);
		if (resp !== RESP_OKAY)
		begin
			n_tests++;
			n_pend--;
			n_err++;
			$display("** Error %s: expected rresp %b, actual %b", name, RESP_OKAY, resp);
		end
		else
			judge(name, exp, act);
	endtask

	task automatic flag_error(input string msg);
		n_err++;
		$display("error: %s", msg);
	endtask

	// fixed priority, master 0 must be acked no later than master 1
	task automatic check_first(input string name, input int c0, input int c1);
		n_tests++;
		if (c0 <= c1)
			$display("ok     %s  master 0 acked at cycle %0d", name, c0);
		else
		begin
			n_err++;
			$display("** Error %s: expected master 0 ack by cycle %0d, actual cycle %0d",
				name, c1, c0);
		end
	endtask

	task automatic report_counts();
		$display("tests run: %0d, errors: %0d", n_tests, n_err);
	endtask

	always @(negedge memread_grant)
	begin
		if (rst_n_i)
		begin
			for (int m = 0; m < `XBAR_NUM_M; m++)
			begin
				if (m_ack_i[m] && !m_req_i[m].req)
					flag_error($sformatf("master %0d saw ack with no request", m));
				if (m_resp_i[m].resp)
				begin
					if (rd_exp[m].size() == 0)
						flag_error($sformatf("master %0d got a response with no read waiting", m));
					else
						judge(rd_name[m].pop_front(), rd_exp[m].pop_front(), m_resp_i[m].rdata);
				end
			end
			if (bvalid_i && bready_i)
			begin
				b_seen  = 1'b1;
				bresp_q = bresp_i;
			end
			if (rvalid_i && rready_i)
			begin
				if (reg_exp.size() == 0)
					flag_error("register read data arrived with no read issued");
				else
					judge_reg(reg_name.pop_front(), reg_exp.pop_front(), rdata_i, rresp_i);
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/xbar_tb.sv
// crossbar testbench top
// clock, reset, two slave memory models with random ack delay and
// read latency, an axi4-lite driver and a table of accesses run in order
`timescale 1ns/10ps
`default_nettype none
`include "xbar_params.svh"

module mem_model
(
	input  logic                 memread_grant,
	input  xbar_pkg::xbar_req_t  req_i,
	input  int unsigned          ack_dly_i,
	input  int unsigned          lat_i,
	output logic                 ack_o,
	output xbar_pkg::xbar_resp_t resp_o
);
	import xbar_pkg::*;

	xbar_data_t mem [64];
	xbar_data_t rd_q [$];
	int         due_q [$];
	int         cyc;
	int         hold;
	logic       acc;
	xbar_req_t  req_s;

	initial
	begin
		for (int i = 0; i < 64; i++)
			mem[i] = '0;
		ack_o  = 1'b0;
		resp_o = '0;
		cyc    = 0;
		hold   = 0;
		forever
		begin
			// sample at the falling edge, act just after the rising edge
			@(negedge memread_grant);
			req_s = req_i;
			acc   = req_i.req && ack_o;
			@(posedge memread_grant);
			#1;
			cyc++;
			resp_o = '0;
			if (acc && req_s.we)
				mem[req_s.addr[7:2]] = req_s.wdata;
			else if (acc)
			begin
				// read data is taken when the request is accepted
				rd_q.push_back(mem[req_s.addr[7:2]]);
				due_q.push_back(cyc + lat_i);
			end
			if (due_q.size() > 0 && due_q[0] <= cyc)
			begin
				resp_o.resp  = 1'b1;
				resp_o.rdata = rd_q.pop_front();
				void'(due_q.pop_front());
			end
			if (acc || !req_s.req)
			begin
				ack_o = 1'b0;
				hold  = ack_dly_i;
			end
			else if (hold == 0)
				ack_o = 1'b1;
			else
				hold--;
		end
	end

endmodule

module xbar_tb;
	import xbar_pkg::*;

	localparam int K_MST  = 0;
	localparam int K_PAIR = 1;
	localparam int K_REGW = 2;
	localparam int K_REGR = 3;

	typedef struct {
		string      name;
		int         kind;
		int         mst;
		logic       we;
		xbar_addr_t addr;
		xbar_data_t wdata;
		xbar_data_t exp;
	} entry_t;

	logic                   rst_n_i;
	logic                   memread_grant;
	xbar_req_t              m_req_i [`XBAR_NUM_M];
	logic [`XBAR_NUM_M-1:0] m_ack_o;
	xbar_resp_t             m_resp_o [`XBAR_NUM_M];
	xbar_req_t              s_req_o [`XBAR_NUM_S];
	logic [`XBAR_NUM_S-1:0] s_ack_i;
	xbar_resp_t             s_resp_i [`XBAR_NUM_S];
	xbar_addr_t             s_axi_awaddr_i;
	logic                   s_axi_awvalid_i;
	logic                   s_axi_awready_o;
	xbar_data_t             s_axi_wdata_i;
	logic                   s_axi_wvalid_i;
	logic                   s_axi_wready_o;
	logic [1:0]             s_axi_bresp_o;
	logic                   s_axi_bvalid_o;
	logic                   s_axi_bready_i;
	xbar_addr_t             s_axi_araddr_i;
	logic                   s_axi_arvalid_i;
	logic                   s_axi_arready_o;
	xbar_data_t             s_axi_rdata_o;
	logic [1:0]             s_axi_rresp_o;
	logic                   s_axi_rvalid_o;
	logic                   s_axi_rready_i;

	int unsigned ack_dly [`XBAR_NUM_S];
	int unsigned lat [`XBAR_NUM_S];
	entry_t      tbl [$];
	int          cycle = 0;
	int          cycle_limit = 0;
	logic        rr_mode;
	logic        idle;
	int          err_cnt;

	xbar_top uut (.*);

	mem_model u_mem0 (.memread_grant, .req_i(s_req_o[0]), .ack_dly_i(ack_dly[0]),
		.lat_i(lat[0]), .ack_o(s_ack_i[0]), .resp_o(s_resp_i[0]));
	mem_model u_mem1 (.memread_grant, .req_i(s_req_o[1]), .ack_dly_i(ack_dly[1]),
		.lat_i(lat[1]), .ack_o(s_ack_i[1]), .resp_o(s_resp_i[1]));

	xbar_checker chk
	(
		.rst_n_i       (rst_n_i),
		.memread_grant (memread_grant),
		.m_req_i       (m_req_i),
		.m_ack_i       (m_ack_o),
		.m_resp_i      (m_resp_o),
		.bvalid_i      (s_axi_bvalid_o),
		.bready_i      (s_axi_bready_i),
		.bresp_i       (s_axi_bresp_o),
		.rvalid_i      (s_axi_rvalid_o),
		.rready_i      (s_axi_rready_i),
		.rdata_i       (s_axi_rdata_o),
		.rresp_i       (s_axi_rresp_o),
		.idle_o        (idle),
		.err_cnt_o     (err_cnt)
	);

	initial
	begin
		memread_grant = 1'b0;
		forever
			#50 memread_grant = ~memread_grant;
	end

	always @(posedge memread_grant)
		cycle <= cycle + 1;

	// one random stream feeds both memory models
	initial
	begin
		void'($urandom(68817));
		forever
		begin
			@(posedge memread_grant);
			for (int s = 0; s < `XBAR_NUM_S; s++)
			begin
				ack_dly[s] = $urandom % 3;
				lat[s]     = 1 + $urandom % 3;
			end
		end
	end

	initial
	begin
		wait (cycle_limit > 0 && cycle >= cycle_limit);
		$display("timeout: run stopped after %0d cycles with accesses unfinished", cycle);
		$display("Result: FAILED");
		$finish;
	end

	task automatic add_entry(input string name, input int kind, input int mst, input logic we,
		input xbar_addr_t addr, input xbar_data_t wdata, input xbar_data_t exp);
		entry_t e;
		e.name  = name;
		e.kind  = kind;
		e.mst   = mst;
		e.we    = we;
		e.addr  = addr;
		e.wdata = wdata;
		e.exp   = exp;
		tbl.push_back(e);
	endtask

	task automatic master_access(input entry_t e, output int ack_cyc);
		if (!e.we)
			chk.expect_read(e.mst, e.name, e.exp);
		m_req_i[e.mst].we    = e.we;
		m_req_i[e.mst].addr  = e.addr;
		m_req_i[e.mst].wdata = e.wdata;
		m_req_i[e.mst].req   = 1'b1;
		do
			@(negedge memread_grant);
		while (!m_ack_o[e.mst]);
		ack_cyc = cycle;
		@(posedge memread_grant);
		#1;
		m_req_i[e.mst].req = 1'b0;
		if (e.we)
			chk.note_write(e.name);
	endtask

	// aw and w are offered together, each dropped after its own handshake
	task automatic reg_write(input entry_t e);
		logic aw_done;
		logic w_done;
		aw_done         = 1'b0;
		w_done          = 1'b0;
		s_axi_awaddr_i  = e.addr;
		s_axi_wdata_i   = e.wdata;
		s_axi_awvalid_i = 1'b1;
		s_axi_wvalid_i  = 1'b1;
		while (!(aw_done && w_done))
		begin
			@(negedge memread_grant);
			if (s_axi_awvalid_i && s_axi_awready_o)
				aw_done = 1'b1;
			if (s_axi_wvalid_i && s_axi_wready_o)
				w_done = 1'b1;
			@(posedge memread_grant);
			#1;
			if (aw_done)
				s_axi_awvalid_i = 1'b0;
			if (w_done)
				s_axi_wvalid_i = 1'b0;
		end
		s_axi_bready_i = 1'b1;
		do
			@(negedge memread_grant);
		while (!s_axi_bvalid_o);
		@(posedge memread_grant);
		#1;
		s_axi_bready_i = 1'b0;
		chk.note_reg_write(e.name);
	endtask

	task automatic reg_read(input entry_t e);
		chk.expect_reg(e.name, e.exp);
		s_axi_araddr_i  = e.addr;
		s_axi_arvalid_i = 1'b1;
		s_axi_rready_i  = 1'b1;
		do
			@(negedge memread_grant);
		while (!s_axi_arready_o);
		@(posedge memread_grant);
		#1;
		s_axi_arvalid_i = 1'b0;
		do
			@(negedge memread_grant);
		while (!s_axi_rvalid_o);
		@(posedge memread_grant);
		#1;
		s_axi_rready_i = 1'b0;
	endtask

	task automatic build_table();
		// reset values
		add_entry("ctrl_reset", K_REGR, 0, 0, `XBAR_REG_CTRL, '0, 32'h7);
		add_entry("err0_reset", K_REGR, 0, 0, `XBAR_REG_ERR0, '0, '0);
		add_entry("err1_reset", K_REGR, 0, 0, `XBAR_REG_ERR1, '0, '0);
		// single master writes and read-back on both slaves
		add_entry("m0_wr_s0", K_MST, 0, 1, 32'h0000_0010, 32'h1111_0000, '0);
		add_entry("m0_wr_s1", K_MST, 0, 1, 32'h8000_0010, 32'h1111_8000, '0);
		add_entry("m1_wr_s0", K_MST, 1, 1, 32'h0000_0020, 32'h2222_0000, '0);
		add_entry("m1_wr_s1", K_MST, 1, 1, 32'h8000_0020, 32'h2222_8000, '0);
		add_entry("m0_rd_s0", K_MST, 0, 0, 32'h0000_0020, '0, 32'h2222_0000);
		add_entry("m0_rd_s1", K_MST, 0, 0, 32'h8000_0020, '0, 32'h2222_8000);
		add_entry("m1_rd_s0", K_MST, 1, 0, 32'h0000_0010, '0, 32'h1111_0000);
		add_entry("m1_rd_s1", K_MST, 1, 0, 32'h8000_0010, '0, 32'h1111_8000);
		add_entry("m0_rd_zero", K_MST, 0, 0, 32'h0000_0030, '0, '0);
		// both masters on slave 0, round-robin
		add_entry("rr_m0_wr", K_PAIR, 0, 1, 32'h0000_0040, 32'h3333_0001, '0);
		add_entry("rr_m1_wr", K_PAIR, 1, 1, 32'h0000_0044, 32'h3333_0002, '0);
		add_entry("rr_m0_rd", K_PAIR, 0, 0, 32'h0000_0044, '0, 32'h3333_0002);
		add_entry("rr_m1_rd", K_PAIR, 1, 0, 32'h0000_0040, '0, 32'h3333_0001);
		add_entry("rr_m0_rd_b", K_PAIR, 0, 0, 32'h0000_0010, '0, 32'h1111_0000);
		add_entry("rr_m1_wr_b", K_PAIR, 1, 1, 32'h0000_0048, 32'h3333_0003, '0);
		add_entry("rr_m0_rd_c", K_PAIR, 0, 0, 32'h0000_0048, '0, 32'h3333_0003);
		add_entry("rr_m1_rd_c", K_PAIR, 1, 0, 32'h0000_0044, '0, 32'h3333_0002);
		// fixed priority
		add_entry("ctrl_fixed", K_REGW, 0, 1, `XBAR_REG_CTRL, 32'h3, '0);
		add_entry("ctrl_rd_fixed", K_REGR, 0, 0, `XBAR_REG_CTRL, '0, 32'h3);
		add_entry("fx_m0_wr", K_PAIR, 0, 1, 32'h0000_0050, 32'h4444_0001, '0);
		add_entry("fx_m1_wr", K_PAIR, 1, 1, 32'h0000_0054, 32'h4444_0002, '0);
		add_entry("fx_m0_rd", K_PAIR, 0, 0, 32'h0000_0054, '0, 32'h4444_0002);
		add_entry("fx_m1_rd", K_PAIR, 1, 0, 32'h0000_0050, '0, 32'h4444_0001);
		// master 0 wins slave 1 last, so round-robin would now favour master 1
		add_entry("fx_m0_rd_s1", K_MST, 0, 0, 32'h8000_0020, '0, 32'h2222_8000);
		add_entry("fx_m0_wr_s1", K_PAIR, 0, 1, 32'h8000_0030, 32'h4444_8001, '0);
		add_entry("fx_m1_wr_s1", K_PAIR, 1, 1, 32'h8000_0034, 32'h4444_8002, '0);
		add_entry("fx_m1_rd_s1", K_MST, 1, 0, 32'h8000_0030, '0, 32'h4444_8001);
		// slave 1 disabled, round-robin again
		add_entry("ctrl_s1_off", K_REGW, 0, 1, `XBAR_REG_CTRL, 32'h5, '0);
		add_entry("off_m0_rd", K_MST, 0, 0, 32'h8000_0010, '0, `XBAR_ERR_DATA);
		add_entry("off_m0_wr", K_MST, 0, 1, 32'h8000_0010, 32'h5555_0000, '0);
		add_entry("off_m1_rd", K_MST, 1, 0, 32'h8000_0020, '0, `XBAR_ERR_DATA);
		add_entry("off_m1_wr", K_MST, 1, 1, 32'h8000_0020, 32'h5555_1111, '0);
		add_entry("off_m1_rd_s0", K_MST, 1, 0, 32'h0000_0020, '0, 32'h2222_0000);
		add_entry("err0_count", K_REGR, 0, 0, `XBAR_REG_ERR0, '0, 32'h2);
		add_entry("err1_count", K_REGR, 0, 0, `XBAR_REG_ERR1, '0, 32'h2);
		add_entry("err0_clear", K_REGW, 0, 1, `XBAR_REG_ERR0, '0, '0);
		add_entry("err1_clear", K_REGW, 0, 1, `XBAR_REG_ERR1, '0, '0);
		add_entry("err0_cleared", K_REGR, 0, 0, `XBAR_REG_ERR0, '0, '0);
		add_entry("err1_cleared", K_REGR, 0, 0, `XBAR_REG_ERR1, '0, '0);
		// writes while disabled must not have reached slave 1
		add_entry("ctrl_s1_on", K_REGW, 0, 1, `XBAR_REG_CTRL, 32'h7, '0);
		add_entry("on_m0_rd_s1", K_MST, 0, 0, 32'h8000_0010, '0, 32'h1111_8000);
		add_entry("on_m1_rd_s1", K_MST, 1, 0, 32'h8000_0020, '0, 32'h2222_8000);
	endtask

	initial
	begin : main
		entry_t e;
		entry_t f;
		int     c0;
		int     c1;
		rst_n_i         = 1'b0;
		m_req_i[0]      = '0;
		m_req_i[1]      = '0;
		s_axi_awaddr_i  = '0;
		s_axi_awvalid_i = 1'b0;
		s_axi_wdata_i   = '0;
		s_axi_wvalid_i  = 1'b0;
		s_axi_bready_i  = 1'b0;
		s_axi_araddr_i  = '0;
		s_axi_arvalid_i = 1'b0;
		s_axi_rready_i  = 1'b0;
		rr_mode         = 1'b1;
		build_table();
		cycle_limit = 200 * tbl.size();
		repeat (3) @(posedge memread_grant);
		#1;
		rst_n_i = 1'b1;
		// idle cycles, nothing may ack or respond
		repeat (4) @(posedge memread_grant);
		#1;
		for (int i = 0; i < tbl.size(); i++)
		begin
			e = tbl[i];
			case (e.kind)
				K_REGW:
				begin
					reg_write(e);
					if (e.addr[7:0] == `XBAR_REG_CTRL)
						rr_mode = e.wdata[2];
				end
				K_REGR:
					reg_read(e);
				K_PAIR:
				begin
					// this entry and the next start in the same cycle
					f = tbl[i+1];
					fork
						master_access(e, c0);
						master_access(f, c1);
					join
					if (!rr_mode && e.we && f.we && (e.addr[31] == f.addr[31]))
						chk.check_first(e.name, c0, c1);
					i++;
				end
				default:
					master_access(e, c0);
			endcase
		end
		wait (idle);
		repeat (4) @(posedge memread_grant);
		chk.report_counts();
		if (err_cnt == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+src
src/xbar_pkg.sv
src/xbar_master_port.sv
src/xbar_slave_port.sv
src/xbar_cfg_regs.sv
src/xbar_top.sv
testbench/xbar_checker.sv
testbench/xbar_tb.sv

//--- Bender.yml
package:
  name: xbar

sources:
  - include_dirs:
      - src
    files:
      - src/xbar_pkg.sv
      - src/xbar_master_port.sv
      - src/xbar_slave_port.sv
      - src/xbar_cfg_regs.sv
      - src/xbar_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/xbar_checker.sv
      - testbench/xbar_tb.sv
